//--- common/valu_settings.svh
/*
 * Datapath and field widths of the vector ALU, included wherever a width is needed
 */
`ifndef VALU_SETTINGS_SVH
`define VALU_SETTINGS_SVH

// vector register and the slice of it handled per cycle
`define VALU_VREG_W 128
`define VALU_OP_W   32
`define VALU_PARTS  4
`define VALU_VMSK_W 16

// vl counts elements, up to 128 for E8 with a group of 8
`define VALU_VL_W   8

// register file address and part counter within a group
`define VALU_ADDR_W 5
`define VALU_CNT_W  5

`endif

//--- common/valu_pkg.sv
/*
 * Types shared by the vector ALU: operations, element width, group size, control state
 */
`default_nettype none

package valu_pkg;

    // element-wise operations, result is vs2 op vs1
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        XOR  = 4'd4,
        SLL  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        MIN  = 4'd8,
        MINU = 4'd9,
        MAX  = 4'd10,
        MAXU = 4'd11
    } valu_op_e;

    // encoding equals log2 of the element size in bytes
    typedef enum logic [1:0] {
        E8  = 2'd0,
        E16 = 2'd1,
        E32 = 2'd2
    } vsew_e;

    // registers per group, fractional sizes are not accepted
    typedef enum logic [1:0] {
        M1 = 2'd0,
        M2 = 2'd1,
        M4 = 2'd2,
        M8 = 2'd3
    } lmul_e;

    typedef enum logic {
        IDLE = 1'b0,
        BUSY = 1'b1
    } valu_state_e;

endpackage

`default_nettype wire

//--- common/valu_part_if.sv
/*
 * Control information of one part, passed from stage to stage along the ALU pipeline
 */
`timescale 1ns/1ps
`default_nettype none

`include "valu_settings.svh"

interface valu_part_if;

    logic                    valid;
    valu_pkg::valu_op_e      op;
    valu_pkg::vsew_e         eew;
    // part index within the whole register group
    logic [`VALU_CNT_W-1:0]  part;
    // last part of a destination register
    logic                    last;
    logic                    masked;
    logic [`VALU_VL_W-1:0]   vl;
    logic [`VALU_ADDR_W-1:0] vd;
    // vs1 comes from the scalar operand
    logic                    scalar;

    modport producer (
        output valid, op, eew, part, last, masked, vl, vd, scalar
    );

    modport consumer (
        input  valid, op, eew, part, last, masked, vl, vd, scalar
    );

endinterface

`default_nettype wire

//--- source/valu_ctrl.sv
/*
 * Operation acceptance and sequencing. Steps through every part of the register group
 * and drives the register file read addresses for the part being fetched.
 */
`timescale 1ns/1ps
`default_nettype none

`include "valu_settings.svh"

module valu_ctrl (
    input  logic                    clk_i,
    input  logic                    rst_ni,

    input  logic                    op_rdy_i,
    output logic                    op_ack_o,
    input  valu_pkg::valu_op_e      op_i,
    input  valu_pkg::vsew_e         vsew_i,
    input  valu_pkg::lmul_e         lmul_i,
    input  logic [`VALU_VL_W-1:0]   vl_i,
    input  logic                    masked_i,
    input  logic                    vs1_vreg_i,
    input  logic [`VALU_ADDR_W-1:0] vs1_addr_i,
    input  logic [31:0]             scalar_i,
    input  logic [`VALU_ADDR_W-1:0] vs2_addr_i,
    input  logic [`VALU_ADDR_W-1:0] vd_addr_i,

    output logic [`VALU_ADDR_W-1:0] vreg_rd1_addr_o,
    output logic [`VALU_ADDR_W-1:0] vreg_rd2_addr_o,
    output logic [31:0]             scalar_o,

    valu_part_if.producer           fetch_part
);

    // counter = {register in group, part in register}
    localparam int unsigned LOW_W = $clog2(`VALU_PARTS);
    localparam int unsigned GRP_W = `VALU_CNT_W - LOW_W;

    valu_pkg::valu_state_e   state_q;
    logic [`VALU_CNT_W-1:0]  cnt_q;

    valu_pkg::valu_op_e      op_q;
    valu_pkg::vsew_e         eew_q;
    valu_pkg::lmul_e         lmul_q;
    logic [`VALU_VL_W-1:0]   vl_q;
    logic                    masked_q;
    logic                    scalar_q;
    logic [31:0]             scalar_data_q;
    logic [`VALU_ADDR_W-1:0] vs1_q, vs2_q, vd_q;

    logic [GRP_W-1:0]        grp_last;
    logic                    reg_end, grp_end, accept;

    always_comb begin
        case (lmul_q)
            valu_pkg::M2: grp_last = GRP_W'(1);
            valu_pkg::M4: grp_last = GRP_W'(3);
            valu_pkg::M8: grp_last = GRP_W'(7);
            default:      grp_last = '0;
        endcase
    end

    assign reg_end = cnt_q[LOW_W-1:0] == LOW_W'(`VALU_PARTS - 1);
    assign grp_end = (state_q == valu_pkg::BUSY) & reg_end
                   & (cnt_q[`VALU_CNT_W-1:LOW_W] == grp_last);

    // a new operation follows the last part of the previous one without a gap
    assign accept   = op_rdy_i & ((state_q == valu_pkg::IDLE) | grp_end);
    assign op_ack_o = accept;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= valu_pkg::IDLE;
            cnt_q   <= '0;
        end else if (accept) begin
            state_q <= valu_pkg::BUSY;
            cnt_q   <= '0;
        end else if (state_q == valu_pkg::BUSY) begin
            state_q <= grp_end ? valu_pkg::IDLE : valu_pkg::BUSY;
            cnt_q   <= cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            op_q          <= op_i;
            eew_q         <= vsew_i;
            lmul_q        <= lmul_i;
            vl_q          <= vl_i;
            masked_q      <= masked_i;
            scalar_q      <= ~vs1_vreg_i;
            scalar_data_q <= scalar_i;
            vs1_q         <= vs1_addr_i;
            vs2_q         <= vs2_addr_i;
            vd_q          <= vd_addr_i;
        end else if ((state_q == valu_pkg::BUSY) && reg_end) begin
            // next register of each group
            vs1_q <= vs1_q + 1'b1;
            vs2_q <= vs2_q + 1'b1;
            vd_q  <= vd_q + 1'b1;
        end
    end

    assign vreg_rd1_addr_o = vs1_q;
    assign vreg_rd2_addr_o = vs2_q;
    assign scalar_o        = scalar_data_q;

    assign fetch_part.valid  = state_q == valu_pkg::BUSY;
    assign fetch_part.op     = op_q;
    assign fetch_part.eew    = eew_q;
    assign fetch_part.part   = cnt_q;
    assign fetch_part.last   = reg_end;
    assign fetch_part.masked = masked_q;
    assign fetch_part.vl     = vl_q;
    assign fetch_part.vd     = vd_q;
    assign fetch_part.scalar = scalar_q;

endmodule

`default_nettype wire

//--- source/valu_operand_shift.sv
/*
 * Operand shift registers: whole source registers are loaded on the first part,
 * then one part per cycle is presented to the execute stage
 */
`timescale 1ns/1ps
`default_nettype none

`include "valu_settings.svh"

module valu_operand_shift (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic [`VALU_VREG_W-1:0] vreg_rd1_i,
    input  logic [`VALU_VREG_W-1:0] vreg_rd2_i,
    input  logic [31:0]            scalar_i,
    output logic [`VALU_OP_W-1:0]  opa_o,
    output logic [`VALU_OP_W-1:0]  opb_o,
    valu_part_if.consumer          fetch_part,
    valu_part_if.producer          ex_part
);

    localparam int unsigned LOW_W = $clog2(`VALU_PARTS);

    logic [`VALU_VREG_W-1:0] sh1_q, sh2_q;
    logic [`VALU_VREG_W-1:0] vs1_data;
    logic                    first;

    assign first = fetch_part.part[LOW_W-1:0] == '0;

    // scalar form fills the whole register with the scalar at element width
    always_comb begin
        case (fetch_part.eew)
            valu_pkg::E8:  vs1_data = {(`VALU_VREG_W / 8){scalar_i[7:0]}};
            valu_pkg::E16: vs1_data = {(`VALU_VREG_W / 16){scalar_i[15:0]}};
            default:       vs1_data = {(`VALU_VREG_W / 32){scalar_i}};
        endcase
        if (!fetch_part.scalar) begin
            vs1_data = vreg_rd1_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ex_part.valid <= 1'b0;
        end else begin
            ex_part.valid <= fetch_part.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fetch_part.valid) begin
            if (first) begin
                sh1_q <= vs1_data;
                sh2_q <= vreg_rd2_i;
            end else begin
                sh1_q <= sh1_q >> `VALU_OP_W;
                sh2_q <= sh2_q >> `VALU_OP_W;
            end
        end
        ex_part.op     <= fetch_part.op;
        ex_part.eew    <= fetch_part.eew;
        ex_part.part   <= fetch_part.part;
        ex_part.last   <= fetch_part.last;
        ex_part.masked <= fetch_part.masked;
        ex_part.vl     <= fetch_part.vl;
        ex_part.vd     <= fetch_part.vd;
        ex_part.scalar <= fetch_part.scalar;
    end

    assign opa_o = sh1_q[`VALU_OP_W-1:0];
    assign opb_o = sh2_q[`VALU_OP_W-1:0];

endmodule

`default_nettype wire

//--- valu_exec/valu_exec.sv
/*
 * Execute stage: fracturable add/subtract, bitwise ops, per-element shifts and min/max,
 * plus the active-element byte mask. Results are registered for the collector.
 */
`timescale 1ns/1ps
`default_nettype none

`include "valu_settings.svh"

module valu_exec (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic [`VALU_OP_W-1:0]    opa_i,
    input  logic [`VALU_OP_W-1:0]    opb_i,
    input  logic [`VALU_VREG_W-1:0]  vmask_i,
    output logic [`VALU_OP_W-1:0]    result_o,
    output logic [`VALU_OP_W/8-1:0]  elem_mask_o,
    valu_part_if.consumer            ex_part,
    valu_part_if.producer            res_part
);

    localparam int unsigned NB   = `VALU_OP_W / 8;
    localparam int unsigned BI_W = $clog2(NB);

    logic                  sub, sra, signed_cmp, is_max;
    logic [BI_W-1:0]       bmsk;
    logic [`VALU_OP_W-1:0] opa_x, sum, shres, res_d;
    logic [NB-1:0]         carry, lt, mask_d;

    function automatic logic [31:0] shift_elem(valu_pkg::valu_op_e op, logic [31:0] v,
                                               logic [4:0] sh);
        case (op)
            valu_pkg::SLL: shift_elem = v << sh;
            valu_pkg::SRL: shift_elem = v >> sh;
            default:       shift_elem = $signed(v) >>> sh;
        endcase
    endfunction

    assign sub = ex_part.op inside {valu_pkg::SUB, valu_pkg::MIN, valu_pkg::MINU,
                                    valu_pkg::MAX, valu_pkg::MAXU};
    assign sra        = ex_part.op == valu_pkg::SRA;
    assign signed_cmp = ex_part.op inside {valu_pkg::MIN, valu_pkg::MAX};
    assign is_max     = ex_part.op inside {valu_pkg::MAX, valu_pkg::MAXU};
    assign opa_x      = sub ? ~opa_i : opa_i;

    // bytes per element minus one
    always_comb begin
        case (ex_part.eew)
            valu_pkg::E16: bmsk = BI_W'(1);
            valu_pkg::E32: bmsk = BI_W'(3);
            default:       bmsk = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // split adder, carry chain is cut at each element start

    always_comb begin
        logic [8:0] bsum;
        logic       cin;
        logic       ovf;
        cin = sub;
        for (int k = 0; k < NB; k++) begin
            if ((BI_W'(k) & bmsk) == '0) begin
                cin = sub;
            end
            bsum           = {1'b0, opb_i[8*k +: 8]} + {1'b0, opa_x[8*k +: 8]} + {8'b0, cin};
            sum[8*k +: 8]  = bsum[7:0];
            carry[k]       = bsum[8];
            cin            = bsum[8];
            // vs2 < vs1, only meaningful in the top byte of an element
            ovf   = (opb_i[8*k+7] ^ opa_i[8*k+7]) & (bsum[7] ^ opb_i[8*k+7]);
            lt[k] = signed_cmp ? (bsum[7] ^ ovf) : ~carry[k];
        end
    end

    // per-element barrel shifts on the low log2(width) bits of vs1
    always_comb begin
        shres = '0;
        case (ex_part.eew)
            valu_pkg::E8: begin
                for (int i = 0; i < NB; i++) begin
                    shres[8*i +: 8] = 8'(shift_elem(ex_part.op,
                        {{24{sra & opb_i[8*i+7]}}, opb_i[8*i +: 8]}, {2'b0, opa_i[8*i +: 3]}));
                end
            end
            valu_pkg::E16: begin
                for (int i = 0; i < NB / 2; i++) begin
                    shres[16*i +: 16] = 16'(shift_elem(ex_part.op,
                        {{16{sra & opb_i[16*i+15]}}, opb_i[16*i +: 16]},
                        {1'b0, opa_i[16*i +: 4]}));
                end
            end
            default: begin
                for (int i = 0; i < NB / 4; i++) begin
                    shres[32*i +: 32] = shift_elem(ex_part.op, opb_i[32*i +: 32],
                                                   opa_i[32*i +: 5]);
                end
            end
        endcase
    end

    always_comb begin
        case (ex_part.op)
            valu_pkg::ADD, valu_pkg::SUB: res_d = sum;
            valu_pkg::AND: res_d = opb_i & opa_i;
            valu_pkg::OR:  res_d = opb_i | opa_i;
            valu_pkg::XOR: res_d = opb_i ^ opa_i;
            valu_pkg::SLL, valu_pkg::SRL, valu_pkg::SRA: res_d = shres;
            default: begin
                // min/max, compare result taken from the element's top byte
                for (int k = 0; k < NB; k++) begin
                    res_d[8*k +: 8] = (lt[BI_W'(k) | bmsk] ^ ~is_max) ? opa_i[8*k +: 8]
                                                                       : opb_i[8*k +: 8];
                end
            end
        endcase
    end

    // active bytes from v0 and vl, by element index within the group
    always_comb begin
        logic [`VALU_CNT_W+BI_W-1:0] idx;
        for (int k = 0; k < NB; k++) begin
            idx       = {ex_part.part, BI_W'(k)} >> ex_part.eew;
            mask_d[k] = (~ex_part.masked | vmask_i[idx]) & (`VALU_VL_W'(idx) < ex_part.vl);
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            res_part.valid <= 1'b0;
        end else begin
            res_part.valid <= ex_part.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        result_o        <= res_d;
        elem_mask_o     <= mask_d;
        res_part.op     <= ex_part.op;
        res_part.eew    <= ex_part.eew;
        res_part.part   <= ex_part.part;
        res_part.last   <= ex_part.last;
        res_part.masked <= ex_part.masked;
        res_part.vl     <= ex_part.vl;
        res_part.vd     <= ex_part.vd;
        res_part.scalar <= ex_part.scalar;
    end

endmodule

`default_nettype wire

//--- source/valu_result_shift.sv
/*
 * Result collector: assembles the parts of one destination register with their byte
 * mask and issues the register file write after the last part
 */
`timescale 1ns/1ps
`default_nettype none

`include "valu_settings.svh"

module valu_result_shift (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic [`VALU_OP_W-1:0]   result_i,
    input  logic [`VALU_OP_W/8-1:0] elem_mask_i,
    output logic                    vreg_wr_en_o,
    output logic [`VALU_ADDR_W-1:0] vreg_wr_addr_o,
    output logic [`VALU_VREG_W-1:0] vreg_wr_o,
    output logic [`VALU_VMSK_W-1:0] vreg_wr_mask_o,
    valu_part_if.consumer           res_part
);

    localparam int unsigned NB = `VALU_OP_W / 8;

    logic [`VALU_VREG_W-1:0] coll_q;
    logic [`VALU_VMSK_W-1:0] mcoll_q;
    logic [`VALU_ADDR_W-1:0] addr_q;
    logic                    wr_en_q;

    // one strobe per finished register
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_en_q <= 1'b0;
        end else begin
            wr_en_q <= res_part.valid & res_part.last;
        end
    end

    // new part enters at the top, part 0 ends up in the low bits
    always_ff @(posedge clk_i) begin
        if (res_part.valid) begin
            coll_q  <= {result_i, coll_q[`VALU_VREG_W-1:`VALU_OP_W]};
            mcoll_q <= {elem_mask_i, mcoll_q[`VALU_VMSK_W-1:NB]};
        end
        if (res_part.valid && res_part.last) begin
            addr_q <= res_part.vd;
        end
    end

    assign vreg_wr_en_o   = wr_en_q;
    assign vreg_wr_addr_o = addr_q;
    assign vreg_wr_o      = coll_q;
    assign vreg_wr_mask_o = mcoll_q;

endmodule

`default_nettype wire

//--- source/valu_top.sv
/*
 * Vector ALU top level. Connects control, operand shift, execute and result stages;
 * the issue and register file sides are plain ports.
 */
`timescale 1ns/1ps
`default_nettype none

`include "valu_settings.svh"

module valu_top (
    input  logic                    clk_i,
    input  logic                    rst_ni,

    // issue side
    input  logic                    op_rdy_i,
    output logic                    op_ack_o,
    input  valu_pkg::valu_op_e      op_i,
    input  valu_pkg::vsew_e         vsew_i,
    input  valu_pkg::lmul_e         lmul_i,
    input  logic [`VALU_VL_W-1:0]   vl_i,
    input  logic                    masked_i,
    input  logic                    vs1_vreg_i,
    input  logic [`VALU_ADDR_W-1:0] vs1_addr_i,
    input  logic [31:0]             scalar_i,
    input  logic [`VALU_ADDR_W-1:0] vs2_addr_i,
    input  logic [`VALU_ADDR_W-1:0] vd_addr_i,

    // register file
    output logic [`VALU_ADDR_W-1:0] vreg_rd1_addr_o,
    output logic [`VALU_ADDR_W-1:0] vreg_rd2_addr_o,
    input  logic [`VALU_VREG_W-1:0] vreg_rd1_i,
    input  logic [`VALU_VREG_W-1:0] vreg_rd2_i,
    input  logic [`VALU_VREG_W-1:0] vreg_mask_i,
    output logic                    vreg_wr_en_o,
    output logic [`VALU_ADDR_W-1:0] vreg_wr_addr_o,
    output logic [`VALU_VREG_W-1:0] vreg_wr_o,
    output logic [`VALU_VMSK_W-1:0] vreg_wr_mask_o
);

    logic [31:0]             scalar;
    logic [`VALU_OP_W-1:0]   opa, opb, result;
    logic [`VALU_OP_W/8-1:0] elem_mask;

    valu_part_if fetch_part ();
    valu_part_if ex_part ();
    valu_part_if res_part ();

    valu_ctrl ctrl0 (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .op_rdy_i        (op_rdy_i),
        .op_ack_o        (op_ack_o),
        .op_i            (op_i),
        .vsew_i          (vsew_i),
        .lmul_i          (lmul_i),
        .vl_i            (vl_i),
        .masked_i        (masked_i),
        .vs1_vreg_i      (vs1_vreg_i),
        .vs1_addr_i      (vs1_addr_i),
        .scalar_i        (scalar_i),
        .vs2_addr_i      (vs2_addr_i),
        .vd_addr_i       (vd_addr_i),
        .vreg_rd1_addr_o (vreg_rd1_addr_o),
        .vreg_rd2_addr_o (vreg_rd2_addr_o),
        .scalar_o        (scalar),
        .fetch_part      (fetch_part.producer)
    );

    valu_operand_shift opsh0 (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .vreg_rd1_i (vreg_rd1_i),
        .vreg_rd2_i (vreg_rd2_i),
        .scalar_i   (scalar),
        .opa_o      (opa),
        .opb_o      (opb),
        .fetch_part (fetch_part.consumer),
        .ex_part    (ex_part.producer)
    );

    valu_exec exec0 (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .opa_i       (opa),
        .opb_i       (opb),
        .vmask_i     (vreg_mask_i),
        .result_o    (result),
        .elem_mask_o (elem_mask),
        .ex_part     (ex_part.consumer),
        .res_part    (res_part.producer)
    );

    valu_result_shift res0 (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .result_i       (result),
        .elem_mask_i    (elem_mask),
        .vreg_wr_en_o   (vreg_wr_en_o),
        .vreg_wr_addr_o (vreg_wr_addr_o),
        .vreg_wr_o      (vreg_wr_o),
        .vreg_wr_mask_o (vreg_wr_mask_o),
        .res_part       (res_part.consumer)
    );

endmodule

`default_nettype wire

//--- verif/valu_asserts.sv
/*
 * Concurrent checks on the vector ALU ports, bound into the top level
 */
`timescale 1ns/1ps
`default_nettype none

`include "valu_settings.svh"

module valu_asserts (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    op_rdy_i,
    input  logic                    op_ack_o,
    input  logic                    vreg_wr_en_o,
    input  logic [`VALU_VMSK_W-1:0] vreg_wr_mask_o,
    input  logic                    part_valid_i,
    input  logic                    part_last_i,
    input  logic [`VALU_CNT_W-1:0]  part_idx_i,
    input  valu_pkg::vsew_e         part_eew_i,
    input  logic [`VALU_VL_W-1:0]   part_vl_i
);

    localparam int unsigned LOW_W = $clog2(`VALU_PARTS);

    logic [1:0]                   since_rst_q;
    logic [1:0]                   since_ack_q;
    logic [`VALU_VL_W-1:0]        vl_q;
    valu_pkg::vsew_e              eew_q;
    logic [`VALU_CNT_W-LOW_W-1:0] grp_q;
    logic                         mask_ok;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            since_rst_q <= '0;
        end else if (since_rst_q != 2'd3) begin
            since_rst_q <= since_rst_q + 1'b1;
        end
    end

    // cycles since the last transfer, saturating at three
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            since_ack_q <= 2'd3;
        end else if (op_ack_o) begin
            since_ack_q <= '0;
        end else if (since_ack_q != 2'd3) begin
            since_ack_q <= since_ack_q + 1'b1;
        end
    end

    // info of the register being written is captured with its last part
    always_ff @(posedge clk_i) begin
        if (part_valid_i && part_last_i) begin
            vl_q  <= part_vl_i;
            eew_q <= part_eew_i;
            grp_q <= part_idx_i[`VALU_CNT_W-1:LOW_W];
        end
    end

    always_comb begin
        logic [7:0] idx;
        mask_ok = 1'b1;
        for (int j = 0; j < `VALU_VMSK_W; j++) begin
            idx = {1'b0, grp_q, 4'(j)} >> eew_q;
            if (vreg_wr_mask_o[j] && idx >= vl_q) begin
                mask_ok = 1'b0;
            end
        end
    end

    // the shortest group still takes one part per cycle for a whole register
    ack_rdy_spacing: assert property (@(posedge clk_i) disable iff (!rst_ni)
        op_ack_o |-> (op_rdy_i && since_ack_q == 2'd3))
        else $error("op_ack_o without op_rdy_i or within one register of the last ack");

    no_early_write: assert property (@(posedge clk_i)
        (since_rst_q != 2'd3) |-> !vreg_wr_en_o)
        else $error("write strobe within three cycles of reset");

    mask_within_vl: assert property (@(posedge clk_i) disable iff (!rst_ni)
        vreg_wr_en_o |-> mask_ok)
        else $error("write mask set for an element at or beyond vl");

endmodule

bind valu_top valu_asserts asrt0 (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .op_rdy_i       (op_rdy_i),
    .op_ack_o       (op_ack_o),
    .vreg_wr_en_o   (vreg_wr_en_o),
    .vreg_wr_mask_o (vreg_wr_mask_o),
    .part_valid_i   (res_part.valid),
    .part_last_i    (res_part.last),
    .part_idx_i     (res_part.part),
    .part_eew_i     (res_part.eew),
    .part_vl_i      (res_part.vl)
);

`default_nettype wire

//--- verif/valu_tb.sv
/*
 * Testbench for the vector ALU. Random operations run against a register file model,
 * and every register write is checked against a reference model.
 */
`timescale 1ns/1ps
`default_nettype none

`include "valu_settings.svh"

module valu_tb;

    localparam int N_OPS   = 80;
    localparam int TIMEOUT = 100;

    logic                    clk_i, rst_ni;
    logic                    op_rdy_i, op_ack_o;
    valu_pkg::valu_op_e      op_i;
    valu_pkg::vsew_e         vsew_i;
    valu_pkg::lmul_e         lmul_i;
    logic [`VALU_VL_W-1:0]   vl_i;
    logic                    masked_i, vs1_vreg_i;
    logic [`VALU_ADDR_W-1:0] vs1_addr_i, vs2_addr_i, vd_addr_i;
    logic [31:0]             scalar_i;
    logic [`VALU_ADDR_W-1:0] vreg_rd1_addr_o, vreg_rd2_addr_o, vreg_wr_addr_o;
    logic [`VALU_VREG_W-1:0] vreg_rd1_i, vreg_rd2_i, vreg_mask_i, vreg_wr_o;
    logic                    vreg_wr_en_o;
    logic [`VALU_VMSK_W-1:0] vreg_wr_mask_o;

    // register file that the DUT only reads
    logic [`VALU_VREG_W-1:0] regs [32];

    // expected writes in issue order
    logic [`VALU_ADDR_W-1:0] exp_addr_q [$];
    logic [`VALU_VREG_W-1:0] exp_data_q [$];
    logic [`VALU_VMSK_W-1:0] exp_mask_q [$];

    int mism_cnt   = 0;
    int other_cnt  = 0;
    int wr_cnt     = 0;
    int exp_wr_cnt = 0;

    valu_top dut0 (.*);

    assign vreg_rd1_i  = regs[vreg_rd1_addr_o];
    assign vreg_rd2_i  = regs[vreg_rd2_addr_o];
    assign vreg_mask_i = regs[0];

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    ////////////////////////////////////////////////////////////////////////////
    // reference model

    // result of one element as b op a with b from vs2 and a from vs1
    function automatic logic [31:0] elem_result(valu_pkg::valu_op_e op, int w,
                                                logic [31:0] a, logic [31:0] b);
        logic [31:0]        m;
        logic [31:0]        sh;
        logic signed [31:0] sa, sb;
        logic [31:0]        r;
        m  = (w == 32) ? 32'hffff_ffff : ((32'd1 << w) - 32'd1);
        sh = a & 32'(w - 1);
        // sign-extended copies for signed compare and arithmetic shift
        sa = $signed(a << (32 - w)) >>> (32 - w);
        sb = $signed(b << (32 - w)) >>> (32 - w);
        case (op)
            valu_pkg::ADD:  r = b + a;
            valu_pkg::SUB:  r = b - a;
            valu_pkg::AND:  r = b & a;
            valu_pkg::OR:   r = b | a;
            valu_pkg::XOR:  r = b ^ a;
            valu_pkg::SLL:  r = b << sh;
            valu_pkg::SRL:  r = b >> sh;
            valu_pkg::SRA:  r = 32'(sb >>> sh);
            valu_pkg::MIN:  r = (sb < sa) ? b : a;
            valu_pkg::MAX:  r = (sb > sa) ? b : a;
            valu_pkg::MINU: r = (b < a) ? b : a;
            default:        r = (b > a) ? b : a;
        endcase
        return r & m;
    endfunction

    // expected writes of the operation on the issue inputs
    task automatic expect_op();
        int                      w, epr, g, idx;
        logic [31:0]             a, b, m;
        logic [`VALU_VREG_W-1:0] d;
        logic [`VALU_VMSK_W-1:0] bm;
        logic [`VALU_ADDR_W-1:0] r1, r2;
        w   = 8 << vsew_i;
        epr = `VALU_VREG_W / w;
        g   = 1 << lmul_i;
        m   = (w == 32) ? 32'hffff_ffff : ((32'd1 << w) - 32'd1);
        for (int r = 0; r < g; r++) begin
            r1 = vs1_addr_i + `VALU_ADDR_W'(r);
            r2 = vs2_addr_i + `VALU_ADDR_W'(r);
            d  = '0;
            bm = '0;
            for (int e = 0; e < epr; e++) begin
                idx = r * epr + e;
                b   = 32'(regs[r2] >> (e * w)) & m;
                a   = vs1_vreg_i ? (32'(regs[r1] >> (e * w)) & m) : (scalar_i & m);
                d   = d | (`VALU_VREG_W'(elem_result(op_i, w, a, b)) << (e * w));
                if ((!masked_i || regs[0][idx]) && idx < int'(vl_i)) begin
                    for (int k = 0; k < w / 8; k++) begin
                        bm[e * (w / 8) + k] = 1'b1;
                    end
                end
            end
            exp_addr_q.push_back(vd_addr_i + `VALU_ADDR_W'(r));
            exp_data_q.push_back(d);
            exp_mask_q.push_back(bm);
            exp_wr_cnt++;
        end
    endtask

    task automatic drive_random_op();
        op_i       = valu_pkg::valu_op_e'(4'($urandom_range(0, 11)));
        vsew_i     = valu_pkg::vsew_e'(2'($urandom_range(0, 2)));
        lmul_i     = valu_pkg::lmul_e'(2'($urandom_range(0, 3)));
        // a little beyond the group so that vl sometimes covers everything
        vl_i       = `VALU_VL_W'($urandom_range(0,
                         (`VALU_VMSK_W >> vsew_i) * (1 << lmul_i) + 8));
        masked_i   = 1'($urandom_range(0, 1));
        vs1_vreg_i = 1'($urandom_range(0, 1));
        vs1_addr_i = `VALU_ADDR_W'($urandom());
        vs2_addr_i = `VALU_ADDR_W'($urandom());
        vd_addr_i  = `VALU_ADDR_W'($urandom());
        scalar_i   = $urandom();
        op_rdy_i   = 1'b1;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // write checker samples the registered outputs at the falling edge

    always @(negedge clk_i) begin
        logic [`VALU_VREG_W-1:0] bytes;
        if (rst_ni && vreg_wr_en_o) begin
            wr_cnt++;
            if (exp_addr_q.size() == 0) begin
                $display("unexpected write to register %0d", vreg_wr_addr_o);
                other_cnt++;
            end else begin
                for (int k = 0; k < `VALU_VMSK_W; k++) begin
                    bytes[8*k +: 8] = {8{exp_mask_q[0][k]}};
                end
                if (vreg_wr_addr_o !== exp_addr_q[0]) begin
                    $display("MISMATCH vreg_wr_addr_o: got %h expected %h",
                             vreg_wr_addr_o, exp_addr_q[0]);
                    mism_cnt++;
                end
                if (vreg_wr_mask_o !== exp_mask_q[0]) begin
                    $display("MISMATCH vreg_wr_mask_o: got %h expected %h",
                             vreg_wr_mask_o, exp_mask_q[0]);
                    mism_cnt++;
                end
                if ((vreg_wr_o & bytes) !== (exp_data_q[0] & bytes)) begin
                    $display("MISMATCH vreg_wr_o: got %h expected %h",
                             vreg_wr_o & bytes, exp_data_q[0] & bytes);
                    mism_cnt++;
                end
                void'(exp_addr_q.pop_front());
                void'(exp_data_q.pop_front());
                void'(exp_mask_q.pop_front());
            end
        end
    end

    initial begin
        int waited;
        bit timed_out;
        void'($urandom(32'hcbd7));
        timed_out  = 1'b0;
        rst_ni     = 1'b0;
        op_rdy_i   = 1'b0;
        op_i       = valu_pkg::ADD;
        vsew_i     = valu_pkg::E8;
        lmul_i     = valu_pkg::M1;
        vl_i       = '0;
        masked_i   = 1'b0;
        vs1_vreg_i = 1'b1;
        vs1_addr_i = '0;
        vs2_addr_i = '0;
        vd_addr_i  = '0;
        scalar_i   = '0;
        for (int i = 0; i < 32; i++) begin
            regs[i] = {$urandom(), $urandom(), $urandom(), $urandom()};
        end

        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;

        for (int n = 0; n < N_OPS && !timed_out; n++) begin
            @(negedge clk_i);
            // mostly back to back with an idle cycle now and then
            if ($urandom_range(0, 7) == 0) begin
                op_rdy_i = 1'b0;
                @(negedge clk_i);
            end
            drive_random_op();
            waited = 0;
            #1;
            while (!op_ack_o && waited < TIMEOUT) begin
                @(negedge clk_i);
                #1;
                waited++;
            end
            if (!op_ack_o) begin
                $display("timeout: op_ack_o stayed low for %0d cycles", TIMEOUT);
                other_cnt++;
                timed_out = 1'b1;
            end else begin
                expect_op();
                @(posedge clk_i);
            end
        end

        @(negedge clk_i);
        op_rdy_i = 1'b0;
        waited   = 0;
        while (exp_addr_q.size() != 0 && waited < TIMEOUT) begin
            @(posedge clk_i);
            waited++;
        end
        if (exp_addr_q.size() != 0) begin
            $display("timeout: %0d expected writes never arrived", exp_addr_q.size());
            other_cnt++;
        end
        // stray writes would show up during this drain
        repeat (8) @(posedge clk_i);
        if (wr_cnt != exp_wr_cnt) begin
            $display("write count %0d differs from the expected %0d", wr_cnt, exp_wr_cnt);
            other_cnt++;
        end

        $display("errors: %0d mismatches, %0d other failures, %0d writes seen",
                 mism_cnt, other_cnt, wr_cnt);
        if (mism_cnt == 0 && other_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+common
common/valu_pkg.sv
common/valu_part_if.sv
source/valu_ctrl.sv
source/valu_operand_shift.sv
valu_exec/valu_exec.sv
source/valu_result_shift.sv
source/valu_top.sv
verif/valu_asserts.sv
verif/valu_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the vector ALU testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module valu_tb -f flist.f -o valu_sim \
    && ./obj_dir/valu_sim 2>&1 | tee sim.log \
    || echo "build or simulation did not complete"

grep -qsx "TB PASSED" sim.log && echo "simulation result: pass" && exit 0 \
    || echo "simulation result: fail"
exit 1
